//--- sim.f
+incdir+include
verilog/fetch_pkg.sv
verilog/bpu_pkg.sv
verilog/pc_register.sv
verilog/btb_table.sv
verilog/fetch_predict.sv
verilog/wb_fetch_master.sv
verilog/fetch_top.sv
tests/tb_fetch.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module tb_fetch -o Vtb_fetch
	./obj_dir/Vtb_fetch > sim.log 2>&1 || true
	cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- include/fetch_ref.svh
// Fetch testbench reference model; included inside the testbench module, uses its BTB model arrays
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

typedef struct {
    logic [3:0]   mask;
    logic [127:0] data;
    logic         take;
    logic [31:0]  dest;
    logic [31:0]  next;
} expect_t;

// Every word holds its own address, scrambled
function automatic logic [127:0] mem_group(input logic [31:0] base);
    logic [127:0] data;
    for (int s = 0; s < 4; s++) begin
        data[32*s +: 32] = (base + 32'(4 * s)) ^ 32'h5a5ac3c3;
    end
    return data;
endfunction

// Galois LFSR, one step per bit taken
function automatic logic take_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 32'h80200003;
    return b;
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], take_bit()};
    return v;
endfunction

function automatic expect_t predict_group(input logic [31:0] pc);
    expect_t                e;
    fetch_pkg::fetch_addr_t a;
    int                     idx;
    logic                   hit;
    a.raw = pc;
    idx = int'(a.f.group[BTB_INDEX_W-1:0]);
    hit = m_valid[idx] && (m_tag[idx] == a.f.group) && (m_slot[idx] >= a.f.slot);
    for (int s = 0; s < 4; s++) begin
        e.mask[s] = (s >= int'(a.f.slot)) && (!hit || s <= int'(m_slot[idx]));
    end
    e.data = mem_group({a.f.group, 4'b0000});
    e.take = hit;
    e.dest = hit ? m_target[idx] : 32'h0;
    e.next = hit ? m_target[idx] : {a.f.group + 28'd1, 4'b0000};
    return e;
endfunction

`endif

//--- tests/tb_fetch.sv
// Testbench for the fetch stage; random memory latency, back-pressure and branch redirects
module tb_fetch;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC    = 32'hbfc00000;
    localparam int          BTB_INDEX_W = 4;
    localparam int          XFER_TOTAL  = 400;
    localparam int          CYCLE_LIMIT = 4000;   // Ten times the transfers

    logic         clk_i;
    logic         rst_n_i;
    logic         wb_cyc_o;
    logic         wb_stb_o;
    logic [31:0]  wb_adr_o;
    logic [127:0] wb_dat_i;
    logic         wb_ack_i;
    logic         stop_fetch_i;
    logic         fetch_valid_o;
    logic [31:0]  fetch_pc_o;
    logic [3:0]   fetch_en_o;
    logic [127:0] fetch_insts_o;
    logic         fetch_pred_take_o;
    logic [31:0]  fetch_pred_dest_o;
    logic         redirect_i;
    logic [31:0]  err_pc_i;
    logic         corr_take_i;
    logic [31:0]  corr_dest_i;

    // Model state
    logic [31:0]  lfsr_q = 32'he68d;
    logic         m_valid  [1 << BTB_INDEX_W];
    logic [27:0]  m_tag    [1 << BTB_INDEX_W];
    logic [1:0]   m_slot   [1 << BTB_INDEX_W];
    logic [31:0]  m_target [1 << BTB_INDEX_W];
    logic [31:0]  model_pc;
    logic [31:0]  last_pc;
    logic [31:0]  trained_pc;
    int           xfer_cnt;
    int           cycle_cnt;
    int           mem_wait;
    logic         mem_busy;
    logic [31:0]  mem_adr;

    `include "fetch_ref.svh"

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .BTB_INDEX_W (BTB_INDEX_W)
    ) u_dut (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .wb_cyc_o          (wb_cyc_o),
        .wb_stb_o          (wb_stb_o),
        .wb_adr_o          (wb_adr_o),
        .wb_dat_i          (wb_dat_i),
        .wb_ack_i          (wb_ack_i),
        .stop_fetch_i      (stop_fetch_i),
        .fetch_valid_o     (fetch_valid_o),
        .fetch_pc_o        (fetch_pc_o),
        .fetch_en_o        (fetch_en_o),
        .fetch_insts_o     (fetch_insts_o),
        .fetch_pred_take_o (fetch_pred_take_o),
        .fetch_pred_dest_o (fetch_pred_dest_o),
        .redirect_i        (redirect_i),
        .err_pc_i          (err_pc_i),
        .corr_take_i       (corr_take_i),
        .corr_dest_i       (corr_dest_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got == exp) else begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////
    // Comparison and model update

    always @(posedge clk_i) begin
        expect_t e;
        int      idx;
        if (rst_n_i) begin
            if (redirect_i) begin
                idx = int'(err_pc_i[4 +: BTB_INDEX_W]);
                m_valid[idx]  = corr_take_i;
                m_tag[idx]    = err_pc_i[31:4];
                m_slot[idx]   = err_pc_i[3:2];
                m_target[idx] = corr_dest_i;
                model_pc = corr_take_i ? corr_dest_i : err_pc_i + 32'd4;
            end else if (fetch_valid_o && !stop_fetch_i) begin
                e = predict_group(model_pc);
                check_value("fetch_pc_o", 128'(fetch_pc_o), 128'(model_pc));
                check_value("fetch_en_o", 128'(fetch_en_o), 128'(e.mask));
                check_value("fetch_insts_o", fetch_insts_o, e.data);
                check_value("fetch_pred_take_o", 128'(fetch_pred_take_o), 128'(e.take));
                check_value("fetch_pred_dest_o", 128'(fetch_pred_dest_o), 128'(e.dest));
                last_pc  = model_pc;
                model_pc = e.next;
                xfer_cnt = xfer_cnt + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: only %0d of %0d groups transferred", xfer_cnt, XFER_TOTAL);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // Stimulus and Wishbone memory model

    // Memory model, run after the inputs of this half cycle are driven
    task automatic serve_memory();
        wb_ack_i = 1'b0;
        #1;
        assert (wb_stb_o == wb_cyc_o) else begin
            $display("Wishbone strobe differs from cycle at t=%0t", $time);
            $display("Finished with errors");
            $fatal(1);
        end
        if (wb_cyc_o) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_adr  = wb_adr_o;
                mem_wait = int'(take_bits(2));   // 0 to 3 wait cycles
            end else begin
                check_value("wb_adr_o", 128'(wb_adr_o), 128'(mem_adr));  // Held until ack
            end
            if (mem_wait == 0) begin
                wb_ack_i = 1'b1;
                wb_dat_i = mem_group(wb_adr_o);
                mem_busy = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    endtask

    task automatic run_until(input int count);
        while (xfer_cnt < count) begin
            @(negedge clk_i);
            stop_fetch_i = (take_bits(2) == 32'd0);
            serve_memory();
        end
    endtask

    task automatic send_redirect(input logic [31:0] pc, input logic take,
                                 input logic [31:0] dest);
        @(negedge clk_i);
        redirect_i   = 1'b1;
        err_pc_i     = pc;
        corr_take_i  = take;
        corr_dest_i  = dest;
        stop_fetch_i = 1'b1;   // No transfer on the redirect edge
        serve_memory();
        @(negedge clk_i);
        redirect_i   = 1'b0;
        stop_fetch_i = 1'b0;
        serve_memory();
    endtask

    initial begin
        logic [1:0]  slot;
        logic [31:0] dest;
        rst_n_i      = 1'b0;
        wb_dat_i     = '0;
        wb_ack_i     = 1'b0;
        stop_fetch_i = 1'b0;
        redirect_i   = 1'b0;
        err_pc_i     = '0;
        corr_take_i  = 1'b0;
        corr_dest_i  = '0;
        model_pc     = RESET_PC;
        last_pc      = RESET_PC;
        trained_pc   = RESET_PC;
        xfer_cnt     = 0;
        cycle_cnt    = 0;
        mem_wait     = 0;
        mem_busy     = 1'b0;
        mem_adr      = '0;
        for (int i = 0; i < (1 << BTB_INDEX_W); i++) m_valid[i] = 1'b0;
        repeat (16) @(negedge clk_i);
        assert (!wb_cyc_o && !fetch_valid_o) else begin
            $display("Bus cycle or output valid active during reset at t=%0t", $time);
            $display("Finished with errors");
            $fatal(1);
        end
        rst_n_i = 1'b1;

        run_until(40);   // Sequential groups from the reset PC

        for (int r = 0; r < 30; r++) begin
            if (r % 3 == 2) begin
                // Untrain from the group base, so a stale entry would still hit
                send_redirect({trained_pc[31:4], 4'b0000}, 1'b0, 32'h0);
            end else begin
                slot = last_pc[3:2] | 2'(take_bits(2));
                dest = RESET_PC + (take_bits(6) << 2);  // Lands mid-group
                trained_pc = {last_pc[31:4], slot, 2'b00};
                send_redirect(trained_pc, 1'b1, dest);
            end
            run_until(40 + 12 * (r + 1));
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verilog/fetch_top.sv
// Instruction-fetch stage top level; connects PC register, BTB, predictor and Wishbone master
module fetch_top #(
    parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC    = 32'hbfc00000,
    parameter int                           BTB_INDEX_W = 4
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    // Wishbone instruction memory
    output logic                              wb_cyc_o,
    output logic                              wb_stb_o,
    output logic [fetch_pkg::ADDR_W-1:0]      wb_adr_o,
    input  logic [fetch_pkg::GROUP_W-1:0]     wb_dat_i,
    input  logic                              wb_ack_i,
    // Instruction queue
    input  logic                              stop_fetch_i,
    output logic                              fetch_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0]      fetch_pc_o,
    output logic [fetch_pkg::GROUP_SLOTS-1:0] fetch_en_o,
    output logic [fetch_pkg::GROUP_W-1:0]     fetch_insts_o,
    output logic                              fetch_pred_take_o,
    output logic [fetch_pkg::ADDR_W-1:0]      fetch_pred_dest_o,
    // Branch redirect
    input  logic                              redirect_i,
    input  logic [fetch_pkg::ADDR_W-1:0]      err_pc_i,
    input  logic                              corr_take_i,
    input  logic [fetch_pkg::ADDR_W-1:0]      corr_dest_i
);

    logic [fetch_pkg::ADDR_W-1:0]      fetch_pc;
    logic [fetch_pkg::ADDR_W-1:0]      pred_next_pc;
    logic                              req_fire;
    logic                              btb_we;
    logic                              btb_wvalid;
    logic [BTB_INDEX_W-1:0]            btb_waddr;
    logic [bpu_pkg::BTB_TAG_W-1:0]     btb_wtag;
    logic [bpu_pkg::SLOT_W-1:0]        btb_wslot;
    logic [fetch_pkg::ADDR_W-1:0]      btb_wtarget;
    logic [BTB_INDEX_W-1:0]            btb_raddr;
    logic                              btb_rvalid;
    logic [bpu_pkg::BTB_TAG_W-1:0]     btb_rtag;
    logic [bpu_pkg::SLOT_W-1:0]        btb_rslot;
    logic [fetch_pkg::ADDR_W-1:0]      btb_rtarget;
    logic [fetch_pkg::GROUP_SLOTS-1:0] pred_mask;
    logic                              pred_take;
    logic [fetch_pkg::ADDR_W-1:0]      pred_dest;

    pc_register #(
        .RESET_PC    (RESET_PC),
        .BTB_INDEX_W (BTB_INDEX_W)
    ) u_pc_register (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_fire_i     (req_fire),
        .pred_next_pc_i (pred_next_pc),
        .redirect_i     (redirect_i),
        .err_pc_i       (err_pc_i),
        .corr_take_i    (corr_take_i),
        .corr_dest_i    (corr_dest_i),
        .fetch_pc_o     (fetch_pc),
        .btb_we_o       (btb_we),
        .btb_wvalid_o   (btb_wvalid),
        .btb_waddr_o    (btb_waddr),
        .btb_wtag_o     (btb_wtag),
        .btb_wslot_o    (btb_wslot),
        .btb_wtarget_o  (btb_wtarget)
    );

    btb_table #(
        .BTB_INDEX_W (BTB_INDEX_W)
    ) u_btb_table (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (btb_we),
        .wvalid_i  (btb_wvalid),
        .waddr_i   (btb_waddr),
        .wtag_i    (btb_wtag),
        .wslot_i   (btb_wslot),
        .wtarget_i (btb_wtarget),
        .raddr_i   (btb_raddr),
        .rvalid_o  (btb_rvalid),
        .rtag_o    (btb_rtag),
        .rslot_o   (btb_rslot),
        .rtarget_o (btb_rtarget)
    );

    fetch_predict #(
        .BTB_INDEX_W (BTB_INDEX_W)
    ) u_fetch_predict (
        .fetch_pc_i     (fetch_pc),
        .rvalid_i       (btb_rvalid),
        .rtag_i         (btb_rtag),
        .rslot_i        (btb_rslot),
        .rtarget_i      (btb_rtarget),
        .raddr_o        (btb_raddr),
        .pred_mask_o    (pred_mask),
        .pred_take_o    (pred_take),
        .pred_dest_o    (pred_dest),
        .pred_next_pc_o (pred_next_pc)
    );

    wb_fetch_master u_wb_fetch_master (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .fetch_pc_i        (fetch_pc),
        .pred_mask_i       (pred_mask),
        .pred_take_i       (pred_take),
        .pred_dest_i       (pred_dest),
        .redirect_i        (redirect_i),
        .stop_fetch_i      (stop_fetch_i),
        .wb_dat_i          (wb_dat_i),
        .wb_ack_i          (wb_ack_i),
        .req_fire_o        (req_fire),
        .wb_cyc_o          (wb_cyc_o),
        .wb_stb_o          (wb_stb_o),
        .wb_adr_o          (wb_adr_o),
        .fetch_valid_o     (fetch_valid_o),
        .fetch_pc_o        (fetch_pc_o),
        .fetch_en_o        (fetch_en_o),
        .fetch_insts_o     (fetch_insts_o),
        .fetch_pred_take_o (fetch_pred_take_o),
        .fetch_pred_dest_o (fetch_pred_dest_o)
    );

endmodule

//--- verilog/wb_fetch_master.sv
// Wishbone classic read master for fetch groups, with redirect cancel and the queue output register
module wb_fetch_master (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [fetch_pkg::ADDR_W-1:0]      fetch_pc_i,
    input  logic [fetch_pkg::GROUP_SLOTS-1:0] pred_mask_i,
    input  logic                              pred_take_i,
    input  logic [fetch_pkg::ADDR_W-1:0]      pred_dest_i,
    input  logic                              redirect_i,
    input  logic                              stop_fetch_i,
    input  logic [fetch_pkg::GROUP_W-1:0]     wb_dat_i,
    input  logic                              wb_ack_i,
    output logic                              req_fire_o,
    output logic                              wb_cyc_o,
    output logic                              wb_stb_o,
    output logic [fetch_pkg::ADDR_W-1:0]      wb_adr_o,
    output logic                              fetch_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0]      fetch_pc_o,
    output logic [fetch_pkg::GROUP_SLOTS-1:0] fetch_en_o,
    output logic [fetch_pkg::GROUP_W-1:0]     fetch_insts_o,
    output logic                              fetch_pred_take_o,
    output logic [fetch_pkg::ADDR_W-1:0]      fetch_pred_dest_o
);

    logic                              run_q;     // Fetch enabled once out of reset
    logic                              busy_q;
    logic                              cancel_q;
    logic [fetch_pkg::ADDR_W-1:0]      req_pc_q;
    logic [fetch_pkg::GROUP_SLOTS-1:0] req_mask_q;
    logic                              req_take_q;
    logic [fetch_pkg::ADDR_W-1:0]      req_dest_q;
    fetch_pkg::fetch_addr_t            cur_pc;
    fetch_pkg::fetch_addr_t            grp_base;
    logic                              out_free;
    logic                              ack;
    logic                              ack_take;

    ////////////////////////////////////////
    // Bus side

    assign out_free   = !fetch_valid_o || !stop_fetch_i;
    assign req_fire_o = run_q && !busy_q && out_free && !redirect_i;
    assign wb_cyc_o   = busy_q || req_fire_o;
    assign wb_stb_o   = wb_cyc_o;

    // First cycle uses the live PC, later ones the latched copy
    assign cur_pc.raw = busy_q ? req_pc_q : fetch_pc_i;

    always_comb begin
        grp_base            = cur_pc;
        grp_base.f.slot     = '0;
        grp_base.f.byte_off = '0;
    end

    assign wb_adr_o = grp_base.raw;
    assign ack      = wb_cyc_o && wb_ack_i;
    assign ack_take = ack && !cancel_q && !redirect_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q    <= 1'b0;
            busy_q   <= 1'b0;
            cancel_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (ack) begin
                busy_q   <= 1'b0;
                cancel_q <= 1'b0;
            end else begin
                if (req_fire_o) begin
                    busy_q <= 1'b1;
                end
                if (redirect_i && busy_q) begin
                    cancel_q <= 1'b1;   // Let the cycle finish, drop its data
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire_o) begin
            req_pc_q   <= fetch_pc_i;
            req_mask_q <= pred_mask_i;
            req_take_q <= pred_take_i;
            req_dest_q <= pred_dest_i;
        end
    end

    ////////////////////////////////////////
    // Output register towards the queue

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_valid_o <= 1'b0;
        end else if (redirect_i) begin
            fetch_valid_o <= 1'b0;
        end else if (ack_take) begin
            fetch_valid_o <= 1'b1;
        end else if (!stop_fetch_i) begin
            fetch_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ack_take) begin
            fetch_pc_o        <= cur_pc.raw;
            fetch_en_o        <= busy_q ? req_mask_q : pred_mask_i;
            fetch_insts_o     <= wb_dat_i;
            fetch_pred_take_o <= busy_q ? req_take_q : pred_take_i;
            fetch_pred_dest_o <= busy_q ? req_dest_q : pred_dest_i;
        end
    end

endmodule

//--- verilog/fetch_predict.sv
// BTB lookup for the current fetch PC; gives the slot mask, the taken prediction and the next PC
module fetch_predict #(
    parameter int BTB_INDEX_W = 4
) (
    input  logic [fetch_pkg::ADDR_W-1:0]      fetch_pc_i,
    input  logic                              rvalid_i,
    input  logic [bpu_pkg::BTB_TAG_W-1:0]     rtag_i,
    input  logic [bpu_pkg::SLOT_W-1:0]        rslot_i,
    input  logic [fetch_pkg::ADDR_W-1:0]      rtarget_i,
    output logic [BTB_INDEX_W-1:0]            raddr_o,
    output logic [fetch_pkg::GROUP_SLOTS-1:0] pred_mask_o,
    output logic                              pred_take_o,
    output logic [fetch_pkg::ADDR_W-1:0]      pred_dest_o,
    output logic [fetch_pkg::ADDR_W-1:0]      pred_next_pc_o
);

    fetch_pkg::fetch_addr_t                pc;
    fetch_pkg::fetch_addr_t                next_grp;
    logic                                  hit;
    logic [fetch_pkg::GROUP_SLOTS-1:0]     start_mask;
    logic [fetch_pkg::GROUP_SLOTS-1:0]     end_mask;

    assign pc.raw  = fetch_pc_i;
    assign raddr_o = pc.f.group[BTB_INDEX_W-1:0];

    // Branch must sit at or after the fetch slot
    assign hit = rvalid_i && (rtag_i == pc.f.group) && (rslot_i >= pc.f.slot);

    ////////////////////////////////////////
    // Slot mask

    assign start_mask = bpu_pkg::FULL_MASK << pc.f.slot;
    assign end_mask   = hit ? (bpu_pkg::FULL_MASK >> ~rslot_i)  // Shift by 3 - slot
                            : bpu_pkg::FULL_MASK;
    assign pred_mask_o = start_mask & end_mask;

    ////////////////////////////////////////
    // Next PC

    always_comb begin
        next_grp            = pc;
        next_grp.f.group    = pc.f.group + 1'b1;
        next_grp.f.slot     = '0;
        next_grp.f.byte_off = '0;
    end

    assign pred_take_o    = hit;
    assign pred_dest_o    = hit ? rtarget_i : '0;
    assign pred_next_pc_o = hit ? rtarget_i : next_grp.raw;

endmodule

//--- verilog/btb_table.sv
// Direct-mapped branch target buffer storage, one write port and one combinational read port
module btb_table #(
    parameter int BTB_INDEX_W = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          we_i,
    input  logic                          wvalid_i,
    input  logic [BTB_INDEX_W-1:0]        waddr_i,
    input  logic [bpu_pkg::BTB_TAG_W-1:0] wtag_i,
    input  logic [bpu_pkg::SLOT_W-1:0]    wslot_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  wtarget_i,
    input  logic [BTB_INDEX_W-1:0]        raddr_i,
    output logic                          rvalid_o,
    output logic [bpu_pkg::BTB_TAG_W-1:0] rtag_o,
    output logic [bpu_pkg::SLOT_W-1:0]    rslot_o,
    output logic [fetch_pkg::ADDR_W-1:0]  rtarget_o
);

    localparam int DEPTH = 1 << BTB_INDEX_W;

    logic [DEPTH-1:0]              valid_q;
    logic [bpu_pkg::BTB_TAG_W-1:0] tag_q    [DEPTH];
    logic [bpu_pkg::SLOT_W-1:0]    slot_q   [DEPTH];
    logic [fetch_pkg::ADDR_W-1:0]  target_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[waddr_i] <= wvalid_i;
        end
    end

    // Entry contents, meaningful only while valid
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_q[waddr_i]    <= wtag_i;
            slot_q[waddr_i]   <= wslot_i;
            target_q[waddr_i] <= wtarget_i;
        end
    end

    assign rvalid_o  = valid_q[raddr_i];
    assign rtag_o    = tag_q[raddr_i];
    assign rslot_o   = slot_q[raddr_i];
    assign rtarget_o = target_q[raddr_i];

endmodule

//--- verilog/pc_register.sv
// Fetch PC register; follows the prediction on each request and builds the BTB update on redirect
module pc_register #(
    parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC    = 32'hbfc00000,
    parameter int                           BTB_INDEX_W = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_fire_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  pred_next_pc_i,
    input  logic                          redirect_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  err_pc_i,
    input  logic                          corr_take_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  corr_dest_i,
    output logic [fetch_pkg::ADDR_W-1:0]  fetch_pc_o,
    output logic                          btb_we_o,
    output logic                          btb_wvalid_o,
    output logic [BTB_INDEX_W-1:0]        btb_waddr_o,
    output logic [bpu_pkg::BTB_TAG_W-1:0] btb_wtag_o,
    output logic [bpu_pkg::SLOT_W-1:0]    btb_wslot_o,
    output logic [fetch_pkg::ADDR_W-1:0]  btb_wtarget_o
);

    fetch_pkg::fetch_addr_t        err_addr;
    logic [fetch_pkg::ADDR_W-1:0]  corr_pc;

    assign err_addr.raw = err_pc_i;

    // Not taken resumes at the word after the branch
    assign corr_pc = corr_take_i ? corr_dest_i : err_pc_i + 32'd4;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_pc_o <= RESET_PC;
        end else if (redirect_i) begin
            fetch_pc_o <= corr_pc;
        end else if (req_fire_i) begin
            fetch_pc_o <= pred_next_pc_i;
        end
    end

    ////////////////////////////////////////
    // BTB training, written on the redirect edge

    assign btb_we_o      = redirect_i;
    assign btb_wvalid_o  = corr_take_i;    // Not taken drops the entry
    assign btb_waddr_o   = err_addr.f.group[BTB_INDEX_W-1:0];
    assign btb_wtag_o    = err_addr.f.group;
    assign btb_wslot_o   = err_addr.f.slot;
    assign btb_wtarget_o = corr_dest_i;

endmodule

//--- verilog/bpu_pkg.sv
// Branch predictor constants used by the BTB, its lookup logic and the PC register
package bpu_pkg;

    // Slot number inside a fetch group
    localparam int SLOT_W = 2;

    // Full group number, so the tag does not depend on the table depth
    localparam int BTB_TAG_W = 28;

    // All four slots enabled
    localparam logic [3:0] FULL_MASK = 4'b1111;

endpackage

//--- verilog/fetch_pkg.sv
// Address and fetch-group formats shared by every fetch-stage module and the testbench
package fetch_pkg;

    ////////////////////////////////////////
    // Widths

    localparam int ADDR_W      = 32;   // Address and instruction word
    localparam int GROUP_SLOTS = 4;    // Instructions per fetch group
    localparam int GROUP_W     = 128;  // One 16-byte group

    ////////////////////////////////////////
    // Fetch address, seen as a raw word or
    // as group, slot and byte fields

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [27:0] group;     // 16-byte group number
            logic [1:0]  slot;      // Word within the group
            logic [1:0]  byte_off;  // Always zero for aligned fetch
        } f;
    } fetch_addr_t;

endpackage
